// ==== core.f ====
src/core_pkg.sv
src/alu.sv
src/regfile.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/hazard_unit.sv
src/memory_stage.sv
src/core.sv
test/tb_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f core.f --top-module tb_core -o tb_core

./obj_dir/tb_core | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
	echo "Simulation passed, see sim.log"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

// ==== test/tb_core.sv ====
`timescale 1ns/1ns

module tb_core;
	import core_pkg::*;

	localparam int PROG_LEN   = 200;
	localparam int PREFIX_LEN = 13;				// Directed forwarding and load-use block
	localparam int FINAL_IDX  = PROG_LEN - 1;	// BEQ x0,x0,0
	localparam int EPI_START  = FINAL_IDX - 31;	// Register dump stores
	localparam int DUMP_BASE  = 512;
	localparam int DATA_WORDS = 64;
	localparam int CLK_PERIOD = 8;
	localparam int TIMEOUT_NS = (PROG_LEN * 4 + 300) * CLK_PERIOD;
	localparam logic [31:0] SEED      = 32'h3046e2aa;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;	// x^32+x^22+x^2+x+1
	localparam logic [PC_W-1:0] FINAL_PC = PC_W'(FINAL_IDX * 4);

	logic CLK;
	logic arst_n;
	logic [XLEN-1:0] inst;
	logic [PC_W-1:0] pc;
	logic [3:0] con_write;
	logic [DMEM_AW-1:0] con_addr;
	logic [XLEN-1:0] con_in;
	logic [XLEN-1:0] con_out;

	logic [31:0] prog [0:PROG_LEN-1];		// Instruction memory
	logic [31:0] pre_data [0:DATA_WORDS-1];
	logic [31:0] m_regs [0:31];				// Model state
	logic [31:0] m_mem [0:(1<<DMEM_AW)-1];
	logic [31:0] lfsr;
	int n_checks = 0;
	int n_errors = 0;

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	core dut0 (
		.CLK(CLK), .arst_n(arst_n), .inst(inst), .pc(pc),
		.con_write(con_write), .con_addr(con_addr), .con_in(con_in), .con_out(con_out)
	);

	// Past the program end the core sees NOPs
	assign inst = (int'(pc[PC_W-1:2]) < PROG_LEN) ? prog[pc[PC_W-1:2]] : NOP_INST;

	// Galois LFSR, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = lfsr >> 1;
			if (b)
				lfsr = lfsr ^ LFSR_TAPS;
			r = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};	// SW only
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, OPC_LUI};
	endfunction

	// One random body instruction, registers x0..x7 keep dependencies dense
	task automatic gen_random_inst(input int idx);
		logic [2:0] kind, f3;
		logic [4:0] rd, rs1, rs2;
		logic [11:0] imm;
		logic alt;
		int k;
		kind = 3'(rand_bits(3));
		rd   = 5'(rand_bits(3));
		rs1  = 5'(rand_bits(3));
		rs2  = 5'(rand_bits(3));
		f3   = 3'(rand_bits(3));
		alt  = 1'b0;
		case (kind)
			3'd0, 3'd1: begin
				if (f3 == 3'b000 || f3 == 3'b101)
					alt = 1'(rand_bits(1));	// SUB or SRA
				prog[idx] = r_type({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
			end
			3'd2, 3'd3: begin
				if (f3 == 3'b001)
					imm = {7'b0, 5'(rand_bits(5))};	// SLLI shamt
				else if (f3 == 3'b101)
					imm = {1'b0, 1'(rand_bits(1)), 5'b0, 5'(rand_bits(5))};
				else
					imm = 12'(rand_bits(12));
				prog[idx] = i_type(imm, rs1, f3, rd, OPC_OP_IMM);
			end
			3'd4: prog[idx] = u_type(20'(rand_bits(20)), rd);
			3'd5: prog[idx] = i_type({4'b0, 6'(rand_bits(6)), 2'b00}, 5'd0, 3'b010, rd, OPC_LOAD);
			3'd6: prog[idx] = s_type({4'b0, 6'(rand_bits(6)), 2'b00}, rs2, 5'd0);
			default: begin
				if (f3[2:1] == 2'b01)
					f3[1] = 1'b0;	// No branch at 010/011, fold to EQ/NE
				k = 1 + int'(rand_bits(3));
				if (idx + k > EPI_START)
					k = EPI_START - idx;	// Never skip the dump
				prog[idx] = b_type(13'(k * 4), rs2, rs1, f3);
			end
		endcase
	endtask

	task automatic build_program();
		prog[0]  = i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM);		// x1 = 5
		prog[1]  = i_type(12'd7, 5'd1, 3'b000, 5'd2, OPC_OP_IMM);		// x1 from MEM
		prog[2]  = r_type(7'b0, 5'd2, 5'd1, 3'b000, 5'd3);				// x1 from WB, x2 from MEM
		prog[3]  = r_type(7'b0100000, 5'd1, 5'd3, 3'b000, 5'd4);		// SUB
		prog[4]  = i_type(12'd8, 5'd0, 3'b010, 5'd5, OPC_LOAD);
		prog[5]  = r_type(7'b0, 5'd4, 5'd5, 3'b000, 5'd6);				// Load-use stall
		prog[6]  = i_type(12'd12, 5'd0, 3'b010, 5'd7, OPC_LOAD);
		prog[7]  = s_type(12'd16, 5'd7, 5'd0);							// Stall on store data
		prog[8]  = i_type(12'd16, 5'd0, 3'b010, 5'd1, OPC_LOAD);		// Reads back the store
		prog[9]  = b_type(13'd8, 5'd7, 5'd1, 3'b001);					// BNE after load
		prog[10] = i_type(12'hfff, 5'd0, 3'b000, 5'd2, OPC_OP_IMM);	// x2 = -1
		prog[11] = u_type(20'habcde, 5'd3);
		prog[12] = r_type(7'b0, 5'd2, 5'd3, 3'b000, 5'd3);
		for (int i = PREFIX_LEN; i < EPI_START; i++)
			gen_random_inst(i);
		// Offset -2048 wraps onto word 512 of the 4 KiB data space
		for (int r = 1; r < 32; r++)
			prog[EPI_START + r - 1] = s_type(12'h800 + 12'(4 * (r - 1)), 5'(r), 5'd0);
		prog[FINAL_IDX] = b_type(13'd0, 5'd0, 5'd0, 3'b000);
	endtask

	// RV32I arithmetic by funct3
	function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		case (f3)
			3'b000: r = alt ? a - b : a + b;
			3'b001: r = a << b[4:0];
			3'b010: r = {31'b0, $signed(a) < $signed(b)};
			3'b011: r = {31'b0, a < b};
			3'b100: r = a ^ b;
			3'b101: begin
				if (alt)
					r = $signed(a) >>> b[4:0];
				else
					r = a >> b[4:0];
			end
			3'b110: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			3'b111: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// Sequential ISA interpreter up to the final loop
	task automatic run_model();
		logic [31:0] ir, a, b, res, addr, imm_i, imm_s, imm_b;
		logic wr;
		int idx, next_idx, steps;
		idx = 0;
		steps = 0;
		for (int r = 0; r < 32; r++)
			m_regs[r] = '0;
		while (idx != FINAL_IDX && steps < 4 * PROG_LEN) begin
			ir    = prog[idx];
			a     = m_regs[ir[19:15]];
			b     = m_regs[ir[24:20]];
			imm_i = {{20{ir[31]}}, ir[31:20]};
			imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			wr = 1'b1;
			res = '0;
			next_idx = idx + 1;
			case (ir[6:0])
				OPC_OP:     res = alu_result(ir[14:12], ir[30], a, b);
				OPC_OP_IMM: res = alu_result(ir[14:12], ir[14:12] == 3'b101 && ir[30], a, imm_i);
				OPC_LUI:    res = {ir[31:12], 12'b0};
				OPC_LOAD: begin
					addr = a + imm_i;
					res = m_mem[addr[DMEM_AW+1:2]];
				end
				OPC_STORE: begin
					wr = 1'b0;
					addr = a + imm_s;
					m_mem[addr[DMEM_AW+1:2]] = b;
				end
				default: begin	// Branches only
					wr = 1'b0;
					if (branch_cond(ir[14:12], a, b))
						next_idx = idx + int'($signed(imm_b)) / 4;
				end
			endcase
			if (wr && ir[11:7] != 5'd0)
				m_regs[ir[11:7]] = res;
			idx = next_idx;
			steps++;
		end
		if (idx != FINAL_IDX) begin
			n_errors++;
			$display("Reference model never reached the final branch loop");
		end
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// con_out is registered, sample one cycle after the address
	task automatic read_word(input logic [DMEM_AW-1:0] addr, output logic [XLEN-1:0] data);
		@(negedge CLK);
		con_addr = addr;
		@(negedge CLK);
		data = con_out;
	endtask

	initial begin
		logic [31:0] data;
		int hits;
		arst_n    = 1'b0;
		con_write = 4'h0;
		con_addr  = '0;
		con_in    = '0;
		lfsr      = SEED;
		for (int w = 0; w < DATA_WORDS; w++) begin
			pre_data[w] = rand_bits(32);
			m_mem[w] = pre_data[w];
		end
		build_program();
		run_model();

		// Data preload while the core sits in reset
		for (int w = 0; w < DATA_WORDS; w++) begin
			@(negedge CLK);
			con_write = 4'hf;
			con_addr  = DMEM_AW'(w);
			con_in    = pre_data[w];
		end
		@(negedge CLK);
		con_write = 4'h0;
		repeat (3) @(negedge CLK);	// Four reset cycles after the preload
		arst_n = 1'b1;

		check("pc after reset", 32'(0), 32'(pc));
		for (int i = 1; i <= 3; i++) begin
			@(negedge CLK);
			check($sformatf("pc at edge %0d", i), 32'(4 * i), 32'(pc));
		end

		while (pc != FINAL_PC)
			@(negedge CLK);
		hits = 0;
		repeat (9) begin	// Taken BEQ every third cycle
			@(negedge CLK);
			if (pc == FINAL_PC)
				hits++;
		end
		check("final loop revisits", 32'(3), 32'(hits));

		for (int r = 1; r < 32; r++) begin
			read_word(DMEM_AW'(DUMP_BASE + r - 1), data);
			check($sformatf("reg x%0d", r), m_regs[r], data);
		end
		for (int w = 0; w < DATA_WORDS; w++) begin
			read_word(DMEM_AW'(w), data);
			check($sformatf("mem word %0d", w), m_mem[w], data);
		end

		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Watchdog sized from the program length
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== src/core.sv ====
`timescale 1ns/1ns

module core (
	input  logic                          CLK,
	input  logic                          arst_n,
	input  logic [core_pkg::XLEN-1:0]     inst,
	output logic [core_pkg::PC_W-1:0]     pc,
	input  logic [3:0]                    con_write,	// Byte enables
	input  logic [core_pkg::DMEM_AW-1:0]  con_addr,		// Word address
	input  logic [core_pkg::XLEN-1:0]     con_in,
	output logic [core_pkg::XLEN-1:0]     con_out
);
	import core_pkg::*;

	// Hazard control
	logic stall, flush;
	fwd_sel_e fwd_a, fwd_b;

	// IF/ID
	logic [XLEN-1:0] id_inst;
	logic [PC_W-1:0] id_pc;
	logic [REG_AW-1:0] id_rs1, id_rs2;

	// ID/EXE
	logic [PC_W-1:0] ex_pc;
	logic [XLEN-1:0] ex_a, ex_b, ex_imm;
	alu_op_e ex_alu_op;
	br_cond_e ex_br_cond;
	logic ex_use_imm, ex_wr_en, ex_is_load, ex_is_store, ex_is_branch;
	logic [REG_AW-1:0] ex_rd, ex_rs1, ex_rs2;

	// EXE outputs and EXE/MEM
	logic branch_taken;
	logic [PC_W-1:0] branch_target;
	logic [DMEM_AW-1:0] dmem_addr;
	logic [XLEN-1:0] dmem_wdata;
	logic dmem_we;
	logic [XLEN-1:0] mem_alu, mem_result;
	logic [REG_AW-1:0] mem_rd;
	logic mem_wr_en, mem_is_load;

	// MEM/WB, doubles as the regfile write port
	logic rf_wr_en;
	logic [REG_AW-1:0] rf_wr_addr;
	logic [XLEN-1:0] rf_wr_data;

	fetch_stage u_fetch (
		.CLK(CLK), .arst_n(arst_n),
		.inst(inst), .stall(stall), .flush(flush),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.pc(pc), .id_inst(id_inst), .id_pc(id_pc)
	);

	decode_stage u_decode (
		.CLK(CLK), .arst_n(arst_n),
		.id_inst(id_inst), .id_pc(id_pc), .stall(stall), .flush(flush),
		.rf_wr_en(rf_wr_en), .rf_wr_addr(rf_wr_addr), .rf_wr_data(rf_wr_data),
		.id_rs1(id_rs1), .id_rs2(id_rs2),
		.ex_pc(ex_pc), .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
		.ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm), .ex_rd(ex_rd),
		.ex_wr_en(ex_wr_en), .ex_is_load(ex_is_load), .ex_is_store(ex_is_store),
		.ex_is_branch(ex_is_branch), .ex_br_cond(ex_br_cond),
		.ex_rs1(ex_rs1), .ex_rs2(ex_rs2)
	);

	execute_stage u_execute (
		.CLK(CLK), .arst_n(arst_n),
		.ex_pc(ex_pc), .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
		.ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm), .ex_rd(ex_rd),
		.ex_wr_en(ex_wr_en), .ex_is_load(ex_is_load), .ex_is_store(ex_is_store),
		.ex_is_branch(ex_is_branch), .ex_br_cond(ex_br_cond),
		.fwd_a(fwd_a), .fwd_b(fwd_b),
		.mem_result(mem_result), .wb_result(rf_wr_data),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
		.mem_alu(mem_alu), .mem_rd(mem_rd), .mem_wr_en(mem_wr_en),
		.mem_is_load(mem_is_load)
	);

	hazard_unit u_hazard (
		.id_rs1(id_rs1), .id_rs2(id_rs2),
		.ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd), .ex_is_load(ex_is_load),
		.mem_rd(mem_rd), .mem_wr_en(mem_wr_en),
		.wb_rd(rf_wr_addr), .wb_wr_en(rf_wr_en),
		.branch_taken(branch_taken),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall), .flush(flush)
	);

	memory_stage u_memory (
		.CLK(CLK), .arst_n(arst_n),
		.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
		.mem_alu(mem_alu), .mem_rd(mem_rd), .mem_wr_en(mem_wr_en),
		.mem_is_load(mem_is_load),
		.con_write(con_write), .con_addr(con_addr), .con_in(con_in),
		.con_out(con_out), .mem_result(mem_result),
		.rf_wr_en(rf_wr_en), .rf_wr_addr(rf_wr_addr), .rf_wr_data(rf_wr_data)
	);

endmodule

// ==== src/memory_stage.sv ====
`timescale 1ns/1ns

module memory_stage (
	input  logic                          CLK,
	input  logic                          arst_n,
	input  logic [core_pkg::DMEM_AW-1:0]  dmem_addr,	// From EXE, one cycle ahead
	input  logic [core_pkg::XLEN-1:0]     dmem_wdata,
	input  logic                          dmem_we,
	input  logic [core_pkg::XLEN-1:0]     mem_alu,
	input  logic [core_pkg::REG_AW-1:0]   mem_rd,
	input  logic                          mem_wr_en,
	input  logic                          mem_is_load,
	input  logic [3:0]                    con_write,
	input  logic [core_pkg::DMEM_AW-1:0]  con_addr,
	input  logic [core_pkg::XLEN-1:0]     con_in,
	output logic [core_pkg::XLEN-1:0]     con_out,
	output logic [core_pkg::XLEN-1:0]     mem_result,
	output logic                          rf_wr_en,
	output logic [core_pkg::REG_AW-1:0]   rf_wr_addr,
	output logic [core_pkg::XLEN-1:0]     rf_wr_data
);
	import core_pkg::*;

	logic [XLEN-1:0] dmem [0:(1<<DMEM_AW)-1];
	logic [XLEN-1:0] load_data;	// Valid while the load is in MEM

	// Core port first, so con bytes win a same-word collision
	always_ff @(posedge CLK) begin
		if (dmem_we)
			dmem[dmem_addr] <= dmem_wdata;
		for (int i = 0; i < 4; i++) begin
			if (con_write[i])
				dmem[con_addr][8*i +: 8] <= con_in[8*i +: 8];
		end
		load_data <= dmem[dmem_addr];
		con_out   <= dmem[con_addr];
	end

	// Loads never forward from MEM thanks to the stall
	assign mem_result = mem_alu;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n)
			rf_wr_en <= 1'b0;
		else
			rf_wr_en <= mem_wr_en;
	end

	always_ff @(posedge CLK) begin
		rf_wr_addr <= mem_rd;
		rf_wr_data <= mem_is_load ? load_data : mem_alu;	// Writeback select
	end

endmodule

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit (
	input  logic [core_pkg::REG_AW-1:0]  id_rs1,
	input  logic [core_pkg::REG_AW-1:0]  id_rs2,
	input  logic [core_pkg::REG_AW-1:0]  ex_rs1,
	input  logic [core_pkg::REG_AW-1:0]  ex_rs2,
	input  logic [core_pkg::REG_AW-1:0]  ex_rd,
	input  logic                         ex_is_load,
	input  logic [core_pkg::REG_AW-1:0]  mem_rd,
	input  logic                         mem_wr_en,
	input  logic [core_pkg::REG_AW-1:0]  wb_rd,
	input  logic                         wb_wr_en,
	input  logic                         branch_taken,
	output core_pkg::fwd_sel_e           fwd_a,
	output core_pkg::fwd_sel_e           fwd_b,
	output logic                         stall,
	output logic                         flush
);
	import core_pkg::*;

	logic load_use;

	// Youngest producer first; x0 never forwards
	function automatic fwd_sel_e pick(input logic [REG_AW-1:0] rs,
			input logic [REG_AW-1:0] m_rd, input logic m_we,
			input logic [REG_AW-1:0] w_rd, input logic w_we);
		if (m_we && m_rd != '0 && m_rd == rs)
			pick = FWD_MEM;
		else if (w_we && w_rd != '0 && w_rd == rs)
			pick = FWD_WB;
		else
			pick = FWD_NONE;
	endfunction

	assign fwd_a = pick(ex_rs1, mem_rd, mem_wr_en, wb_rd, wb_wr_en);
	assign fwd_b = pick(ex_rs2, mem_rd, mem_wr_en, wb_rd, wb_wr_en);

	// Load data reaches EXE only from WB
	assign load_use = ex_is_load && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

	assign flush = branch_taken;
	assign stall = load_use && !branch_taken;	// Dependent is on the wrong path anyway

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
	input  logic                          CLK,
	input  logic                          arst_n,
	input  logic [core_pkg::PC_W-1:0]     ex_pc,
	input  logic [core_pkg::XLEN-1:0]     ex_a,
	input  logic [core_pkg::XLEN-1:0]     ex_b,
	input  logic [core_pkg::XLEN-1:0]     ex_imm,
	input  core_pkg::alu_op_e             ex_alu_op,
	input  logic                          ex_use_imm,
	input  logic [core_pkg::REG_AW-1:0]   ex_rd,
	input  logic                          ex_wr_en,
	input  logic                          ex_is_load,
	input  logic                          ex_is_store,
	input  logic                          ex_is_branch,
	input  core_pkg::br_cond_e            ex_br_cond,
	input  core_pkg::fwd_sel_e            fwd_a,
	input  core_pkg::fwd_sel_e            fwd_b,
	input  logic [core_pkg::XLEN-1:0]     mem_result,
	input  logic [core_pkg::XLEN-1:0]     wb_result,
	output logic                          branch_taken,
	output logic [core_pkg::PC_W-1:0]     branch_target,
	output logic [core_pkg::DMEM_AW-1:0]  dmem_addr,
	output logic [core_pkg::XLEN-1:0]     dmem_wdata,
	output logic                          dmem_we,
	output logic [core_pkg::XLEN-1:0]     mem_alu,
	output logic [core_pkg::REG_AW-1:0]   mem_rd,
	output logic                          mem_wr_en,
	output logic                          mem_is_load
);
	import core_pkg::*;

	logic [XLEN-1:0] op_a, rs2_val, op_b, alu_y;
	logic zero, less, cond;

	function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
			input logic [XLEN-1:0] rf_val, input logic [XLEN-1:0] mem_val,
			input logic [XLEN-1:0] wb_val);
		case (sel)
			FWD_MEM: fwd_mux = mem_val;
			FWD_WB:  fwd_mux = wb_val;
			default: fwd_mux = rf_val;
		endcase
	endfunction

	assign op_a    = fwd_mux(fwd_a, ex_a, mem_result, wb_result);
	assign rs2_val = fwd_mux(fwd_b, ex_b, mem_result, wb_result);
	assign op_b    = ex_use_imm ? ex_imm : rs2_val;

	alu u_alu (.a(op_a), .b(op_b), .op(ex_alu_op), .y(alu_y), .zero(zero), .less(less));

	always_comb begin
		case (ex_br_cond)
			BR_EQ:         cond = zero;
			BR_NE:         cond = ~zero;
			BR_LT, BR_LTU: cond = less;	// Signedness chosen by ALU op
			default:       cond = ~less;	// GE, GEU
		endcase
	end

	assign branch_taken  = ex_is_branch & cond;
	assign branch_target = ex_pc + ex_imm[PC_W-1:0];

	// Store leaves straight to the data memory
	assign dmem_addr  = alu_y[DMEM_AW+1:2];
	assign dmem_wdata = rs2_val;
	assign dmem_we    = ex_is_store;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			mem_wr_en   <= 1'b0;
			mem_is_load <= 1'b0;
		end else begin
			mem_wr_en   <= ex_wr_en;
			mem_is_load <= ex_is_load;
		end
	end

	always_ff @(posedge CLK) begin
		mem_alu <= alu_y;
		mem_rd  <= ex_rd;
	end

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
	input  logic                         CLK,
	input  logic                         arst_n,
	input  logic [core_pkg::XLEN-1:0]    id_inst,
	input  logic [core_pkg::PC_W-1:0]    id_pc,
	input  logic                         stall,
	input  logic                         flush,
	input  logic                         rf_wr_en,
	input  logic [core_pkg::REG_AW-1:0]  rf_wr_addr,
	input  logic [core_pkg::XLEN-1:0]    rf_wr_data,
	output logic [core_pkg::REG_AW-1:0]  id_rs1,
	output logic [core_pkg::REG_AW-1:0]  id_rs2,
	output logic [core_pkg::PC_W-1:0]    ex_pc,
	output logic [core_pkg::XLEN-1:0]    ex_a,
	output logic [core_pkg::XLEN-1:0]    ex_b,
	output logic [core_pkg::XLEN-1:0]    ex_imm,
	output core_pkg::alu_op_e            ex_alu_op,
	output logic                         ex_use_imm,
	output logic [core_pkg::REG_AW-1:0]  ex_rd,
	output logic                         ex_wr_en,
	output logic                         ex_is_load,
	output logic                         ex_is_store,
	output logic                         ex_is_branch,
	output core_pkg::br_cond_e           ex_br_cond,
	output logic [core_pkg::REG_AW-1:0]  ex_rs1,
	output logic [core_pkg::REG_AW-1:0]  ex_rs2
);
	import core_pkg::*;

	logic [2:0] funct3;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u;
	logic [XLEN-1:0] imm, rd1, rd2;
	alu_op_e alu_op;
	logic use_imm, wr_en, is_load, is_store, is_branch;

	// funct3 to ALU op; SUB only exists in register form
	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic f7_b5,
			input logic is_reg);
		case (f3)
			3'b000: arith_op = (is_reg && f7_b5) ? ALU_SUB : ALU_ADD;
			3'b001: arith_op = ALU_SLL;
			3'b010: arith_op = ALU_SLT;
			3'b011: arith_op = ALU_SLTU;
			3'b100: arith_op = ALU_XOR;
			3'b101: arith_op = f7_b5 ? ALU_SRA : ALU_SRL;	// Also SRAI
			3'b110: arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	endfunction

	assign funct3 = id_inst[14:12];
	assign imm_i = {{20{id_inst[31]}}, id_inst[31:20]};
	assign imm_s = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
	assign imm_b = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
		id_inst[11:8], 1'b0};
	assign imm_u = {id_inst[31:12], 12'b0};

	always_comb begin
		imm       = imm_i;
		alu_op    = ALU_ADD;	// Address add for LW/SW
		use_imm   = 1'b0;
		wr_en     = 1'b0;
		is_load   = 1'b0;
		is_store  = 1'b0;
		is_branch = 1'b0;
		id_rs1    = id_inst[19:15];
		id_rs2    = id_inst[24:20];
		case (opcode_e'(id_inst[6:0]))
			OPC_OP: begin
				wr_en  = 1'b1;
				alu_op = arith_op(funct3, id_inst[30], 1'b1);
			end
			OPC_OP_IMM: begin
				wr_en   = 1'b1;
				use_imm = 1'b1;
				id_rs2  = '0;	// Immediate bits, no real source
				alu_op  = arith_op(funct3, id_inst[30], 1'b0);
			end
			OPC_LUI: begin
				wr_en   = 1'b1;
				use_imm = 1'b1;
				imm     = imm_u;
				alu_op  = ALU_PASS_B;
				id_rs1  = '0;
				id_rs2  = '0;
			end
			OPC_LOAD: begin
				wr_en   = 1'b1;
				is_load = 1'b1;
				use_imm = 1'b1;
				id_rs2  = '0;
			end
			OPC_STORE: begin
				is_store = 1'b1;
				use_imm  = 1'b1;
				imm      = imm_s;	// rs2 still read for store data
			end
			OPC_BRANCH: begin
				is_branch = funct3[2] | ~funct3[1];	// funct3 010/011 are not branches
				imm       = imm_b;
				alu_op    = funct3[1] ? ALU_SLTU : ALU_SUB;
			end
			default: begin	// Unknown opcode becomes a bubble
				id_rs1 = '0;
				id_rs2 = '0;
			end
		endcase
	end

	regfile u_rf (
		.CLK(CLK), .arst_n(arst_n),
		.rs1(id_rs1), .rs2(id_rs2),
		.wr_en(rf_wr_en), .wr_addr(rf_wr_addr), .wr_data(rf_wr_data),
		.rd1(rd1), .rd2(rd2)
	);

	// ID/EXE enables; stall or flush inserts a bubble
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			ex_wr_en     <= 1'b0;
			ex_is_load   <= 1'b0;
			ex_is_store  <= 1'b0;
			ex_is_branch <= 1'b0;
		end else if (stall || flush) begin
			ex_wr_en     <= 1'b0;
			ex_is_load   <= 1'b0;
			ex_is_store  <= 1'b0;
			ex_is_branch <= 1'b0;
		end else begin
			ex_wr_en     <= wr_en;
			ex_is_load   <= is_load;
			ex_is_store  <= is_store;
			ex_is_branch <= is_branch;
		end
	end

	always_ff @(posedge CLK) begin
		ex_pc      <= id_pc;
		ex_a       <= rd1;
		ex_b       <= rd2;
		ex_imm     <= imm;
		ex_alu_op  <= alu_op;
		ex_use_imm <= use_imm;
		ex_rd      <= id_inst[11:7];
		ex_br_cond <= br_cond_e'(funct3);
		ex_rs1     <= id_rs1;	// For EXE forwarding match
		ex_rs2     <= id_rs2;
	end

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage (
	input  logic                       CLK,
	input  logic                       arst_n,
	input  logic [core_pkg::XLEN-1:0]  inst,			// From external instruction memory
	input  logic                       stall,
	input  logic                       flush,
	input  logic                       branch_taken,
	input  logic [core_pkg::PC_W-1:0]  branch_target,
	output logic [core_pkg::PC_W-1:0]  pc,
	output logic [core_pkg::XLEN-1:0]  id_inst,
	output logic [core_pkg::PC_W-1:0]  id_pc
);
	import core_pkg::*;

	logic [PC_W-1:0] pc_next;

	// Redirect from EXE wins over sequential fetch
	assign pc_next = branch_taken ? branch_target : pc + PC_W'(4);

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			pc      <= '0;
			id_inst <= NOP_INST;	// Pipeline starts empty
		end else begin
			if (!stall)
				pc <= pc_next;		// Hazard unit drops stall on a taken branch
			if (flush)
				id_inst <= NOP_INST;	// Kill wrong-path fetch
			else if (!stall)
				id_inst <= inst;
		end
	end

	always_ff @(posedge CLK) begin
		if (!stall)
			id_pc <= pc;	// Only meaningful alongside a live id_inst
	end

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ns

module regfile (
	input  logic                         CLK,
	input  logic                         arst_n,
	input  logic [core_pkg::REG_AW-1:0]  rs1,
	input  logic [core_pkg::REG_AW-1:0]  rs2,
	input  logic                         wr_en,
	input  logic [core_pkg::REG_AW-1:0]  wr_addr,
	input  logic [core_pkg::XLEN-1:0]    wr_data,
	output logic [core_pkg::XLEN-1:0]    rd1,
	output logic [core_pkg::XLEN-1:0]    rd2
);
	import core_pkg::*;

	logic [XLEN-1:0] regs [1:(1<<REG_AW)-1];	// x0 has no storage

	// x0 reads zero, a same-cycle write shows through
	function automatic logic [XLEN-1:0] read_reg(input logic [REG_AW-1:0] addr);
		if (addr == '0)
			read_reg = '0;
		else if (wr_en && wr_addr == addr)
			read_reg = wr_data;
		else
			read_reg = regs[addr];
	endfunction

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < (1 << REG_AW); i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	always_comb begin
		rd1 = read_reg(rs1);
		rd2 = read_reg(rs2);
	end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ns

module alu (
	input  logic [core_pkg::XLEN-1:0]  a,
	input  logic [core_pkg::XLEN-1:0]  b,
	input  core_pkg::alu_op_e          op,
	output logic [core_pkg::XLEN-1:0]  y,
	output logic                       zero,	// Result is zero
	output logic                       less		// a < b, unsigned only for SLTU
);
	import core_pkg::*;

	assign less = (op == ALU_SLTU) ? (a < b) : ($signed(a) < $signed(b));

	always_comb begin
		case (op)
			ALU_ADD:    y = a + b;
			ALU_SUB:    y = a - b;
			ALU_SLL:    y = a << b[4:0];
			ALU_SLT,
			ALU_SLTU:   y = {{(XLEN-1){1'b0}}, less};
			ALU_XOR:    y = a ^ b;
			ALU_SRL:    y = a >> b[4:0];
			ALU_SRA:    y = $unsigned($signed(a) >>> b[4:0]);
			ALU_OR:     y = a | b;
			ALU_AND:    y = a & b;
			ALU_PASS_B: y = b;		// LUI
			default:    y = '0;
		endcase
	end

	assign zero = (y == '0);

endmodule

// ==== src/core_pkg.sv ====
package core_pkg;

	localparam int XLEN    = 32;	// Data and register width
	localparam int PC_W    = 12;	// Byte address into instruction memory
	localparam int REG_AW  = 5;		// 32 architectural registers
	localparam int DMEM_AW = 10;	// 1024 data words

	localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;	// ADDI x0,x0,0

	// Major opcodes still decoded
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

	// Same encoding as funct3 of the branches
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} br_cond_e;

	typedef enum logic [1:0] {
		FWD_NONE,	// Operand from ID/EXE
		FWD_MEM,	// EXE/MEM ALU value
		FWD_WB		// Writeback value
	} fwd_sel_e;

endpackage
